/* sim/snd_cases.txt */
# op  arg  data  mask  err  (all hex)
# arg: APB address, play index or tick count; data: write, read or snd value
RD          002  00    ff    0
WR          001  81    00    0
RD          001  81    ff    0
RD          003  00    00    1
WR          010  55    00    1
WR          900  5a    00    0
RD          900  5a    ff    0
# Pointer table entry 1 points at 0x200, entry 2 at 0x300
WR          812  00    00    0
WR          813  02    00    0
WR          814  00    00    0
WR          815  03    00    0
WR          a00  90    00    0
WR          a01  70    00    0
WR          a02  ff    00    0
WR          a03  01    00    0
WR          a04  00    00    0
WR          b00  ff    00    0
WR          b01  00    00    0
RD          a02  ff    ff    0
RD          815  03    ff    0
# Gain level 1 playback with host reads in flight
PLAY        01   00    00    0
EXPECT_SND  3    0000  00    0
EXPECT_SND  1    0050  00    0
EXPECT_SND  1    ffb0  00    0
EXPECT_SND  1    027b  00    0
EXPECT_SND  1    fd85  00    0
EXPECT_SND  1    0000  00    0
RD          002  80    80    0
RD          a00  90    ff    0
RD          a03  01    ff    0
RD          812  00    ff    0
RD          b00  ff    ff    0
WAIT        0    00    00    0
RD          002  00    ff    0
# Entry 2 at gain levels 0, 2 and 3, then with pcm_en clear
WR          001  80    00    0
PLAY        02   00    00    0
EXPECT_SND  3    0000  00    0
EXPECT_SND  1    00fe  00    0
EXPECT_SND  1    0000  00    0
WAIT        0    00    00    0
WR          001  82    00    0
PLAY        02   00    00    0
EXPECT_SND  3    0000  00    0
EXPECT_SND  1    0379  00    0
EXPECT_SND  1    0000  00    0
WAIT        0    00    00    0
WR          001  83    00    0
PLAY        02   00    00    0
EXPECT_SND  3    0000  00    0
EXPECT_SND  1    0477  00    0
EXPECT_SND  1    0000  00    0
WAIT        0    00    00    0
WR          001  03    00    0
PLAY        02   00    00    0
EXPECT_SND  5    0000  00    0
WAIT        0    00    00    0
RD          002  00    ff    0

/* project.f */
+incdir+hdl
hdl/snd_pkg.sv
hdl/snd_regs.sv
hdl/pcm_player.sv
hdl/mem_arbiter.sv
hdl/sample_ram.sv
hdl/snd_top.sv
sim/snd_checker.sv
sim/snd_tb.sv

/* Makefile */
# Verilator build and run of the sound block testbench

VERILATOR ?= verilator
TOP       ?= snd_tb
LOG       ?= sim.log
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run into $(LOG), fail on reported errors"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP LOG FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/snd_tb.sv */
// ####################
// Sound block testbench
// Clock, reset and APB stimulus driven from the
// cases file, with a checker on the DUT outputs
// ####################

`timescale 1ns/100ps
`include "snd_macros.svh"

module snd_tb import snd_pkg::*; ();

    localparam int APB_LIMIT   = 32;
    localparam int DRAIN_LIMIT = 64 * `SND_SAMPLE_DIV;

    logic               clk;
    logic               comb_rstn;
    apb_req_t           apb_req;
    apb_rsp_t           apb_rsp;
    logic               sample;
    logic signed [15:0] snd;
    int                 apb_errors;
    int                 snd_errors;
    int                 other_errors;
    logic               timed_out;

    snd_top UUT (
        .clk         (clk),
        .comb_rstn   (comb_rstn),
        .snd_apb_req (apb_req),
        .snd_apb_rsp (apb_rsp),
        .sample      (sample),
        .snd         (snd)
    );

    snd_checker u_chk (
        .clk          (clk),
        .apb_rsp      (apb_rsp),
        .sample       (sample),
        .snd          (snd),
        .apb_errors   (apb_errors),
        .snd_errors   (snd_errors),
        .other_errors (other_errors)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Setup phase, access phase, then wait for pready
    task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                                input logic [7:0] wdata);
        int waited;
        waited = 0;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready && waited < APB_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!apb_rsp.pready) begin
            u_chk.note_failure($sformatf("APB transfer to 0x%03h never saw pready", addr));
            timed_out = 1'b1;
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic wait_snd_checks();
        int waited;
        waited = 0;
        while (u_chk.snd_pending() > 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (u_chk.snd_pending() > 0) begin
            u_chk.note_failure("sample ticks stopped before all expected snd values were seen");
            timed_out = 1'b1;
        end
    endtask

    // CTRL write, then line up with the first tick that sees the trigger
    task automatic start_play(input string name, input logic [5:0] idx);
        wait_snd_checks();
        if (!timed_out) begin
            u_chk.expect_apb(name, 8'h00, 8'h00, 1'b0);
            apb_transfer(1'b1, 12'h000, {2'b00, idx});
            repeat (2) @(posedge clk);
        end
    endtask

    task automatic run_line(input string line, input int lineno);
        string       op;
        string       name;
        logic [31:0] arg;
        logic [31:0] data;
        logic [31:0] mask;
        logic [31:0] err;
        int          n;
        int          k;
        op   = "";
        arg  = '0;
        data = '0;
        mask = '0;
        err  = '0;
        n    = $sscanf(line, "%s %h %h %h %h", op, arg, data, mask, err);
        name = $sformatf("%0s line %0d", op, lineno);
        if (n < 1 || op.getc(0) == "#") begin
            n = 0;
        end else if (op == "WR") begin
            u_chk.expect_apb(name, 8'h00, 8'h00, err[0]);
            apb_transfer(1'b1, arg[11:0], data[7:0]);
        end else if (op == "RD") begin
            u_chk.expect_apb(name, data[7:0], mask[7:0], err[0]);
            apb_transfer(1'b0, arg[11:0], 8'h00);
        end else if (op == "PLAY") begin
            start_play(name, arg[5:0]);
        end else if (op == "EXPECT_SND") begin
            for (k = 0; k < int'(arg); k++) begin
                u_chk.expect_snd($sformatf("%0s tick %0d", name, k), data[15:0]);
            end
        end else if (op == "WAIT") begin
            wait_snd_checks();
        end else begin
            u_chk.note_failure($sformatf("unknown operation %0s on line %0d", op, lineno));
        end
    endtask

    initial begin
        int    fd;
        int    lineno;
        string line;
        comb_rstn = 1'b0;
        apb_req   = '0;
        timed_out = 1'b0;
        lineno    = 0;
        repeat (4) @(posedge clk);
        comb_rstn <= 1'b1;
        fd = $fopen("sim/snd_cases.txt", "r");
        if (fd == 0) begin
            u_chk.note_failure("cannot open sim/snd_cases.txt");
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                lineno++;
                run_line(line, lineno);
            end
            $fclose(fd);
        end
        if (!timed_out) begin
            wait_snd_checks();
        end
        $display("Error counts: %0d APB, %0d snd, %0d other",
                 apb_errors, snd_errors, other_errors);
        if (apb_errors + snd_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* sim/snd_checker.sv */
// ####################
// Sound block checker
// Compares APB responses and snd values at sample
// ticks against expected values, counts mismatches
// ####################

`timescale 1ns/100ps
`include "snd_macros.svh"

module snd_checker import snd_pkg::*; (
    input  logic        clk,
    input  apb_rsp_t    apb_rsp,
    input  logic        sample,
    input  logic [15:0] snd,
    output int          apb_errors,
    output int          snd_errors,
    output int          other_errors
);

    int          n_apb = 0;
    int          n_snd = 0;
    int          n_other = 0;
    logic        apb_armed = 1'b0;
    string       apb_name;
    logic [7:0]  apb_data;
    logic [7:0]  apb_mask;
    logic        apb_err;
    string       snd_names [$];
    logic [15:0] snd_values [$];
    string       snd_name;
    logic [15:0] snd_exp;
    int          tick_gap = 0;
    logic        tick_seen = 1'b0;

    // Armed before the transfer starts, consumed on pready
    task automatic expect_apb(input string name, input logic [7:0] data,
                              input logic [7:0] mask, input logic err);
        apb_name  = name;
        apb_data  = data;
        apb_mask  = mask;
        apb_err   = err;
        apb_armed = 1'b1;
    endtask

    // One entry per sample tick, in playback order
    task automatic expect_snd(input string name, input logic [15:0] value);
        snd_names.push_back(name);
        snd_values.push_back(value);
    endtask

    function automatic int snd_pending();
        return snd_values.size();
    endfunction

    task automatic note_failure(input string what);
        $display("Failure: %0s", what);
        n_other++;
    endtask

    // Outputs are stable half a cycle after the rising edge
    always @(negedge clk) begin
        if (apb_armed && apb_rsp.pready) begin
            apb_armed = 1'b0;
            if (apb_rsp.pslverr !== apb_err) begin
                $display("** Error %0s: pslverr expected %0b, actual %0b",
                         apb_name, apb_err, apb_rsp.pslverr);
                n_apb++;
            end else if ((apb_rsp.prdata & apb_mask) !== (apb_data & apb_mask)) begin
                $display("** Error %0s: prdata expected 0x%02h (mask 0x%02h), actual 0x%02h",
                         apb_name, apb_data, apb_mask, apb_rsp.prdata);
                n_apb++;
            end
        end
        // Ticks are single-cycle pulses a fixed number of clocks apart
        if (sample) begin
            if (tick_seen && tick_gap != `SND_SAMPLE_DIV) begin
                $display("** Error sample period: expected %0d, actual %0d",
                         `SND_SAMPLE_DIV, tick_gap);
                n_snd++;
            end
            tick_seen = 1'b1;
            tick_gap  = 1;
        end else begin
            tick_gap++;
        end
        if (sample && snd_values.size() > 0) begin
            snd_exp  = snd_values.pop_front();
            snd_name = snd_names.pop_front();
            if (snd !== snd_exp) begin
                $display("** Error %0s: snd expected 0x%04h, actual 0x%04h",
                         snd_name, snd_exp, snd);
                n_snd++;
            end
        end
    end

    assign apb_errors   = n_apb;
    assign snd_errors   = n_snd;
    assign other_errors = n_other;

endmodule

/* hdl/snd_top.sv */
// ####################
// Sound block top level
// Register block and PCM player sharing one
// sample memory through the arbiter
// ####################

`timescale 1ns/100ps

module snd_top import snd_pkg::*; (
    input  logic               clk,
    input  logic               comb_rstn,
    input  apb_req_t           snd_apb_req,
    output apb_rsp_t           snd_apb_rsp,
    output logic               sample,
    output logic signed [15:0] snd
);

    mem_req_t   host_req;
    mem_rsp_t   host_rsp;
    mem_req_t   player_req;
    mem_rsp_t   player_rsp;
    mem_req_t   ram_req;
    mem_rsp_t   ram_rsp;
    logic       play;
    logic [5:0] play_index;
    logic [1:0] gain_level;
    logic       pcm_en;
    logic       busy;
    pcm_state_e pcm_st;

    snd_regs u_regs (
        .clk        (clk),
        .comb_rstn  (comb_rstn),
        .apb_req    (snd_apb_req),
        .apb_rsp    (snd_apb_rsp),
        .mem_req    (host_req),
        .mem_rsp    (host_rsp),
        .play       (play),
        .play_index (play_index),
        .gain_level (gain_level),
        .pcm_en     (pcm_en),
        .busy       (busy),
        .pcm_st     (pcm_st)
    );

    pcm_player u_player (
        .clk        (clk),
        .comb_rstn  (comb_rstn),
        .play       (play),
        .play_index (play_index),
        .gain_level (gain_level),
        .pcm_en     (pcm_en),
        .mem_req    (player_req),
        .mem_rsp    (player_rsp),
        .busy       (busy),
        .pcm_st     (pcm_st),
        .sample     (sample),
        .snd        (snd)
    );

    mem_arbiter u_arbiter (
        .clk        (clk),
        .comb_rstn  (comb_rstn),
        .player_req (player_req),
        .player_rsp (player_rsp),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .ram_req    (ram_req),
        .ram_rsp    (ram_rsp)
    );

    sample_ram u_ram (
        .clk     (clk),
        .ram_req (ram_req),
        .ram_rsp (ram_rsp)
    );

endmodule

/* hdl/sample_ram.sv */
// ####################
// Sample memory
// Single-port byte RAM, one cycle read latency
// ####################

`timescale 1ns/100ps
`include "snd_macros.svh"

module sample_ram import snd_pkg::*; (
    input  logic     clk,
    input  mem_req_t ram_req,
    output mem_rsp_t ram_rsp
);

    logic [7:0] mem [0:(1 << `SND_MEM_AW)-1];
    logic       valid_q;
    logic [7:0] rdata_q;

    always_ff @(posedge clk) begin
        valid_q <= ram_req.req;
        if (ram_req.req) begin
            if (ram_req.we) begin
                mem[ram_req.addr] <= ram_req.wdata;
            end
            rdata_q <= mem[ram_req.addr];
        end
    end

    assign ram_rsp = '{valid: valid_q, rdata: rdata_q};

endmodule

/* hdl/mem_arbiter.sv */
// ####################
// Sample memory arbiter
// Fixed priority for the player, grant held
// until the memory answers
// ####################

`timescale 1ns/100ps

module mem_arbiter import snd_pkg::*; (
    input  logic     clk,
    input  logic     comb_rstn,
    input  mem_req_t player_req,
    output mem_rsp_t player_rsp,
    input  mem_req_t host_req,
    output mem_rsp_t host_rsp,
    output mem_req_t ram_req,
    input  mem_rsp_t ram_rsp
);

    logic pending;
    logic own_player;
    logic sel_player;

    // While a grant is open the owner keeps the mux
    assign sel_player = pending ? own_player : player_req.req;

    always_comb begin
        ram_req     = sel_player ? player_req : host_req;
        ram_req.req = ~pending & (player_req.req | host_req.req);
    end

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            pending    <= 1'b0;
            own_player <= 1'b0;
        end else if (!pending) begin
            if (player_req.req | host_req.req) begin
                pending    <= 1'b1;
                own_player <= player_req.req;
            end
        end else if (ram_rsp.valid) begin
            pending <= 1'b0;
        end
    end

    assign player_rsp = '{valid: pending & own_player & ram_rsp.valid, rdata: ram_rsp.rdata};
    assign host_rsp   = '{valid: pending & ~own_player & ram_rsp.valid, rdata: ram_rsp.rdata};

endmodule

/* hdl/pcm_player.sv */
// ####################
// PCM sample player
// Fetches a start pointer from the table, streams
// unsigned bytes until a zero and scales them by
// the selected gain into a signed 16-bit output
// ####################

`timescale 1ns/100ps
`include "snd_macros.svh"

module pcm_player import snd_pkg::*; (
    input  logic               clk,
    input  logic               comb_rstn,
    input  logic               play,
    input  logic [5:0]         play_index,
    input  logic [1:0]         gain_level,
    input  logic               pcm_en,
    output mem_req_t           mem_req,
    input  mem_rsp_t           mem_rsp,
    output logic               busy,
    output pcm_state_e         pcm_st,
    output logic               sample,
    output logic signed [15:0] snd
);

    localparam int DIV_W = $clog2(`SND_SAMPLE_DIV);

    pcm_state_e             state;
    logic [DIV_W-1:0]       div_cnt;
    logic                   tick;
    logic                   play_pend;
    logic [5:0]             idx_q;
    logic                   req_q;
    logic [`SND_MEM_AW-1:0] rd_addr;
    logic                   end_flag;
    logic [7:0]             ptr_lo;
    logic [7:0]             ptr_hi;
    logic [7:0]             held;
    logic [3:0]             gain_mult;
    logic signed [8:0]      diff;
    logic signed [15:0]     prod;

    assign tick = (div_cnt == DIV_W'(`SND_SAMPLE_DIV - 1));

    // Gain stage on the held byte
    always_comb begin
        case (gain_level)
            2'd0:    gain_mult = 4'd2;
            2'd1:    gain_mult = 4'd5;
            2'd2:    gain_mult = 4'd7;
            default: gain_mult = 4'd9;
        endcase
        diff = $signed({1'b0, held}) - $signed({1'b0, `SND_PCM_IDLE});
        prod = diff * $signed({1'b0, gain_mult});
    end

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            div_cnt   <= '0;
            sample    <= 1'b0;
            state     <= IDLE;
            play_pend <= 1'b0;
            idx_q     <= '0;
            req_q     <= 1'b0;
            rd_addr   <= '0;
            end_flag  <= 1'b0;
            snd       <= '0;
        end else begin
            sample  <= tick;
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (mem_rsp.valid) begin
                req_q <= 1'b0;
                if (state == STREAM) begin
                    end_flag <= (mem_rsp.rdata == 8'h00) || (&rd_addr);
                end
            end
            if (tick) begin
                snd <= '0;
                if (play_pend) begin
                    play_pend <= 1'b0;
                    state     <= PTR_LO;
                    rd_addr   <= `SND_MEM_AW'(`SND_TABLE_BASE) + `SND_MEM_AW'({idx_q, 1'b0});
                    req_q     <= 1'b1;
                end else begin
                    case (state)
                        PTR_LO: begin
                            state   <= PTR_HI;
                            rd_addr <= rd_addr + 1'b1;
                            req_q   <= 1'b1;
                        end
                        PTR_HI: begin
                            state   <= STREAM;
                            rd_addr <= {ptr_hi[`SND_MEM_AW-9:0], ptr_lo};
                            req_q   <= 1'b1;
                        end
                        STREAM: begin
                            if (end_flag) begin
                                state <= IDLE;
                            end else begin
                                snd     <= pcm_en ? prod : 16'sd0;
                                rd_addr <= rd_addr + 1'b1;
                                req_q   <= 1'b1;
                            end
                        end
                        default: ;
                    endcase
                end
            end
            // A new trigger waits for the next tick
            if (play) begin
                play_pend <= 1'b1;
                idx_q     <= play_index;
            end
        end
    end

    // Pointer bytes and the last nonzero sample
    always_ff @(posedge clk) begin
        if (mem_rsp.valid) begin
            case (state)
                PTR_LO: ptr_lo <= mem_rsp.rdata;
                PTR_HI: ptr_hi <= mem_rsp.rdata;
                STREAM: if (mem_rsp.rdata != 8'h00) held <= mem_rsp.rdata;
                default: ;
            endcase
        end
    end

    assign mem_req = '{req: req_q, we: 1'b0, addr: rd_addr, wdata: 8'h00};
    assign busy    = (state != IDLE) | play_pend;
    assign pcm_st  = state;

endmodule

/* hdl/snd_regs.sv */
// ####################
// APB register block
// Control, gain and status registers plus a byte
// window onto the shared sample memory
// ####################

`timescale 1ns/100ps
`include "snd_macros.svh"

module snd_regs import snd_pkg::*; (
    input  logic       clk,
    input  logic       comb_rstn,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    output mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp,
    output logic       play,
    output logic [5:0] play_index,
    output logic [1:0] gain_level,
    output logic       pcm_en,
    input  logic       busy,
    input  pcm_state_e pcm_st
);

    logic                   setup;
    logic                   win;
    logic                   known;
    logic                   reg_wr;
    logic                   mem_done;
    reg_addr_e              reg_off;
    logic                   pready_q;
    logic                   pslverr_q;
    logic [7:0]             prdata_q;
    logic                   mreq_q;
    logic                   mwe_q;
    logic [`SND_MEM_AW-1:0] maddr_q;
    logic [7:0]             mwdata_q;

    assign setup    = apb_req.psel & ~apb_req.penable;
    assign win      = apb_req.paddr[11];
    assign reg_off  = reg_addr_e'(apb_req.paddr[10:0]);
    assign known    = reg_off inside {CTRL, GAIN, STATUS};
    assign reg_wr   = apb_req.psel & apb_req.penable & pready_q & apb_req.pwrite & ~win;
    assign mem_done = mreq_q & mem_rsp.valid;

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            pready_q   <= 1'b0;
            pslverr_q  <= 1'b0;
            mreq_q     <= 1'b0;
            play       <= 1'b0;
            play_index <= '0;
            gain_level <= '0;
            pcm_en     <= 1'b0;
        end else begin
            pready_q <= 1'b0;
            play     <= 1'b0;
            // Registers answer in the first access cycle
            if (setup) begin
                if (win) begin
                    mreq_q    <= 1'b1;
                    pslverr_q <= 1'b0;
                end else begin
                    pready_q  <= 1'b1;
                    pslverr_q <= ~known;
                end
            end
            // Window request held until the arbiter returns data
            if (mem_done) begin
                mreq_q   <= 1'b0;
                pready_q <= 1'b1;
            end
            if (reg_wr) begin
                case (reg_off)
                    CTRL: begin
                        play       <= 1'b1;
                        play_index <= apb_req.pwdata[5:0];
                    end
                    GAIN: begin
                        gain_level <= apb_req.pwdata[1:0];
                        pcm_en     <= apb_req.pwdata[7];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (setup) begin
            maddr_q  <= apb_req.paddr[`SND_MEM_AW-1:0];
            mwe_q    <= apb_req.pwrite;
            mwdata_q <= apb_req.pwdata;
            case (reg_off)
                CTRL:    prdata_q <= {2'b00, play_index};
                GAIN:    prdata_q <= {pcm_en, 5'd0, gain_level};
                STATUS:  prdata_q <= {busy, 5'd0, pcm_st};
                default: prdata_q <= 8'h00;
            endcase
        end
        if (mem_done) begin
            prdata_q <= mem_rsp.rdata;
        end
    end

    assign apb_rsp = '{prdata: prdata_q, pready: pready_q, pslverr: pslverr_q};
    assign mem_req = '{req: mreq_q, we: mwe_q, addr: maddr_q, wdata: mwdata_q};

endmodule

/* hdl/snd_pkg.sv */
// ####################
// Sound block types
// Bus structs and state encodings shared by the RTL
// ####################

`include "snd_macros.svh"

package snd_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [7:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [7:0] prdata;
        logic       pready;
        logic       pslverr;
    } apb_rsp_t;

    // One byte access to the sample memory
    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [`SND_MEM_AW-1:0] addr;
        logic [7:0]             wdata;
    } mem_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        PTR_LO = 2'd1,
        PTR_HI = 2'd2,
        STREAM = 2'd3
    } pcm_state_e;

    // Register offsets, window bit clear
    typedef enum logic [10:0] {
        CTRL   = 11'h000,
        GAIN   = 11'h001,
        STATUS = 11'h002
    } reg_addr_e;

endpackage

/* hdl/snd_macros.svh */
// ####################
// Sound block sizes and addresses
// Sample memory geometry, pointer table location,
// sample rate divider and idle sample level
// ####################

`ifndef SND_MACROS_SVH
`define SND_MACROS_SVH

// 1 KB sample memory
`define SND_MEM_AW      10

// Byte address of the 16-bit pointer table
`define SND_TABLE_BASE  'h010

// Clocks per output sample
`define SND_SAMPLE_DIV  16

// Unsigned midpoint of an 8-bit sample
`define SND_PCM_IDLE    8'h80

`endif
